//--- logic/fb_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data word, descriptor and depth shared by the frame buffer blocks
// Both FIFOs use FB_DEPTH and hold at most FB_DEPTH-1 entries
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fb_types_pkg;

    localparam int unsigned FB_DATA_W = 32;                   // Bits per stream word
    localparam int unsigned FB_DEPTH  = 16;                   // Slots per FIFO
    localparam int unsigned FB_LEN_W  = $clog2(FB_DEPTH + 1); // Holds FB_DEPTH itself, 5 bits

    // One stream word
    typedef logic [FB_DATA_W-1:0] fb_word_t;

    // Per-frame descriptor, written once the frame is complete
    typedef struct packed {
        logic [FB_LEN_W-1:0] len;   // Stored words, never zero
        logic                trunc; // Words were discarded
    } fb_desc_t;

endpackage : fb_types_pkg

`default_nettype wire

//--- logic/fb_csr_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register map of the frame buffer control block
// Counter registers clear on any write, max length reads back clamped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fb_csr_pkg;

    localparam int unsigned CSR_ADDR_W = 2;
    localparam int unsigned CSR_DATA_W = 16;

    // Register addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MAX_LEN = 2'd0; // RW word limit per frame
    localparam logic [CSR_ADDR_W-1:0] CSR_FRAMES  = 2'd1; // Committed frames
    localparam logic [CSR_ADDR_W-1:0] CSR_TRUNC   = 2'd2; // Truncated frames
    localparam logic [CSR_ADDR_W-1:0] CSR_DROP    = 2'd3; // Dropped frames

    localparam int unsigned MAX_LEN_RST = 8; // Limit after reset

endpackage : fb_csr_pkg

`default_nettype wire

//--- logic/fifo_0r1w.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular FIFO, head readable combinationally, writes land at the edge
// Holds DEPTH-1 entries. Push while full or pop while empty is illegal
// DEPTH need not be a power of two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fifo_0r1w #(
    parameter type         T     = logic [31:0],
    parameter int unsigned DEPTH = 16
) (
    input  wire logic i_clk,
    input  wire logic i_rst_n,

    // Write side, one-cycle latency
    input  wire logic i_push,
    input  wire T     i_wdata,
    output      logic o_full,

    // Read side, zero latency
    input  wire logic i_pop,
    output      logic o_empty,
    output      T     o_rdata
);

    localparam int unsigned AWIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T                  mem [DEPTH];  // Payload storage
    logic [AWIDTH-1:0] push_idx;     // Next slot to write
    logic [AWIDTH-1:0] pop_idx;      // Current head
    logic [AWIDTH-1:0] push_idx_nxt;
    logic [AWIDTH-1:0] pop_idx_nxt;

    always_comb begin
        // Wrap by compare so odd depths work
        push_idx_nxt = (push_idx == AWIDTH'(DEPTH - 1)) ? '0 : push_idx + 1'b1;
        pop_idx_nxt  = (pop_idx  == AWIDTH'(DEPTH - 1)) ? '0 : pop_idx  + 1'b1;

        o_full  = (push_idx_nxt == pop_idx); // One slot kept free
        o_empty = (push_idx == pop_idx);
        o_rdata = mem[pop_idx];              // Head mux
    end

    // Index control
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            push_idx <= '0;
            pop_idx  <= '0;
        end else begin
            if (i_push) begin
                push_idx <= push_idx_nxt;
            end
            if (i_pop) begin
                pop_idx <= pop_idx_nxt;
            end
        end
    end

    // Storage write, kept apart for distributed RAM
    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[push_idx] <= i_wdata;
        end
    end

endmodule : fifo_0r1w

`default_nettype wire

//--- logic/frame_writer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ingress framing. Never stalls, words that do not fit are discarded
// Descriptor FIFO is assumed never full, each entry owns a stored word
// Event pulses are registered, one cycle after the closing push
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module frame_writer import fb_types_pkg::*; (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,

    // Ingress stream
    input  wire logic                i_in_push,
    input  wire logic                i_in_last,
    input  wire fb_word_t            i_in_data,

    input  wire logic                i_data_full,
    input  wire logic [FB_LEN_W-1:0] i_max_len,

    // FIFO write sides
    output      logic                o_data_push,
    output      fb_word_t            o_data_wdata,
    output      logic                o_desc_push,
    output      fb_desc_t            o_desc_wdata,

    // Event pulses to the register block
    output      logic                o_commit,
    output      logic                o_trunc,
    output      logic                o_drop
);

    logic [FB_LEN_W-1:0] word_cnt;    // Words stored for the open frame
    logic                trunc_flag;  // Sticky, something was discarded
    logic                accept;
    logic                frame_end;
    logic                has_words;
    logic                frame_trunc;
    logic [FB_LEN_W-1:0] frame_len;

    always_comb begin
        accept      = i_in_push && !i_data_full && (word_cnt < i_max_len);
        frame_end   = i_in_push && i_in_last;
        frame_len   = word_cnt + FB_LEN_W'(accept); // Accepted last word counts
        has_words   = (frame_len != '0);
        frame_trunc = trunc_flag || (i_in_push && !accept); // Includes a lost last word

        o_data_push        = accept;
        o_data_wdata       = i_in_data;
        o_desc_push        = frame_end && has_words; // Empty frames leave no trace
        o_desc_wdata.len   = frame_len;
        o_desc_wdata.trunc = frame_trunc;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            word_cnt   <= '0;
            trunc_flag <= 1'b0;
            o_commit   <= 1'b0;
            o_trunc    <= 1'b0;
            o_drop     <= 1'b0;
        end else begin
            o_commit <= frame_end && has_words;
            o_trunc  <= frame_end && has_words && frame_trunc;
            o_drop   <= frame_end && !has_words;

            if (frame_end) begin   // Start fresh for the next frame
                word_cnt   <= '0;
                trunc_flag <= 1'b0;
            end else begin
                if (accept) word_cnt <= word_cnt + 1'b1;
                if (i_in_push && !accept) trunc_flag <= 1'b1;
            end
        end
    end

endmodule : frame_writer

`default_nettype wire

//--- logic/frame_reader.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Egress side. A frame is visible only once its descriptor exists
// i_out_pop is ignored while o_out_valid is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module frame_reader import fb_types_pkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_rst_n,

    // FIFO heads
    input  wire logic     i_desc_empty,
    input  wire fb_desc_t i_desc_rdata,
    input  wire fb_word_t i_data_rdata,

    // Egress stream
    input  wire logic     i_out_pop,
    output      logic     o_out_valid,
    output      fb_word_t o_out_data,
    output      logic     o_out_last,
    output      logic     o_out_trunc,

    // FIFO pops
    output      logic     o_data_pop,
    output      logic     o_desc_pop
);

    logic [FB_LEN_W-1:0] rd_cnt; // Words already taken from the head frame

    always_comb begin
        o_out_valid = !i_desc_empty;   // Whole frame is stored
        o_out_data  = i_data_rdata;
        o_out_last  = o_out_valid && (rd_cnt == i_desc_rdata.len - FB_LEN_W'(1));
        o_out_trunc = o_out_valid && i_desc_rdata.trunc; // Same on every word of the frame

        o_data_pop = i_out_pop && o_out_valid;
        o_desc_pop = o_data_pop && o_out_last; // Retire with the final word
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            rd_cnt <= '0;
        end else if (o_desc_pop) begin
            rd_cnt <= '0;
        end else if (o_data_pop) begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

endmodule : frame_reader

`default_nettype wire

//--- logic/fb_csr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control registers. Max length write of 0 stores 1, large values clamp
// Counters saturate, any write clears the addressed counter
// LEN_W must be below CSR_DATA_W
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fb_csr import fb_csr_pkg::*; #(
    parameter int unsigned LEN_W = 5
) (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,

    // Register bus
    input  wire logic                  i_csr_we,
    input  wire logic [CSR_ADDR_W-1:0] i_csr_addr,
    input  wire logic [CSR_DATA_W-1:0] i_csr_wdata,
    output      logic [CSR_DATA_W-1:0] o_csr_rdata,

    // Events from ingress
    input  wire logic                  i_commit,
    input  wire logic                  i_trunc,
    input  wire logic                  i_drop,

    output      logic [LEN_W-1:0]      o_max_len
);

    logic [LEN_W-1:0]      max_len_q;
    logic [LEN_W-1:0]      max_len_wr;  // Write data after fixup
    logic [CSR_DATA_W-1:0] frames_q;
    logic [CSR_DATA_W-1:0] trunc_q;
    logic [CSR_DATA_W-1:0] drop_q;

    // Clear beats increment, top value sticks
    function automatic logic [CSR_DATA_W-1:0] cnt_next(
        input logic [CSR_DATA_W-1:0] cnt,
        input logic                  inc,
        input logic                  clr
    );
        if (clr) return '0;
        if (inc && (cnt != '1)) return cnt + 1'b1;
        return cnt;
    endfunction

    always_comb begin
        if (i_csr_wdata == '0) begin
            max_len_wr = LEN_W'(1);             // Zero would drop everything
        end else if ((i_csr_wdata >> LEN_W) != '0) begin
            max_len_wr = '1;                    // Beyond the length field
        end else begin
            max_len_wr = i_csr_wdata[LEN_W-1:0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            max_len_q <= LEN_W'(MAX_LEN_RST);
            frames_q  <= '0;
            trunc_q   <= '0;
            drop_q    <= '0;
        end else begin
            if (i_csr_we && (i_csr_addr == CSR_MAX_LEN)) max_len_q <= max_len_wr;
            frames_q <= cnt_next(frames_q, i_commit, i_csr_we && (i_csr_addr == CSR_FRAMES));
            trunc_q  <= cnt_next(trunc_q,  i_trunc,  i_csr_we && (i_csr_addr == CSR_TRUNC));
            drop_q   <= cnt_next(drop_q,   i_drop,   i_csr_we && (i_csr_addr == CSR_DROP));
        end
    end

    // Combinational read
    always_comb begin
        case (i_csr_addr)
            CSR_MAX_LEN: o_csr_rdata = CSR_DATA_W'(max_len_q);
            CSR_FRAMES:  o_csr_rdata = frames_q;
            CSR_TRUNC:   o_csr_rdata = trunc_q;
            CSR_DROP:    o_csr_rdata = drop_q;
            default:     o_csr_rdata = '0;
        endcase
    end

    assign o_max_len = max_len_q;

endmodule : fb_csr

`default_nettype wire

//--- logic/frame_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store-and-forward frame buffer, single clock
// Frames appear at egress one cycle after their closing word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module frame_buffer import fb_types_pkg::*, fb_csr_pkg::*; (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,

    // Ingress
    input  wire logic                  i_in_push,
    input  wire logic                  i_in_last,
    input  wire fb_word_t              i_in_data,
    output      logic                  o_in_full,

    // Egress
    output      logic                  o_out_valid,
    output      fb_word_t              o_out_data,
    output      logic                  o_out_last,
    output      logic                  o_out_trunc,
    input  wire logic                  i_out_pop,

    // Register bus
    input  wire logic                  i_csr_we,
    input  wire logic [CSR_ADDR_W-1:0] i_csr_addr,
    input  wire logic [CSR_DATA_W-1:0] i_csr_wdata,
    output      logic [CSR_DATA_W-1:0] o_csr_rdata
);

    logic                data_push, data_pop, data_full;
    fb_word_t            data_wdata, data_rdata;
    logic                desc_push, desc_pop, desc_empty;
    fb_desc_t            desc_wdata, desc_rdata;
    logic                ev_commit, ev_trunc, ev_drop;
    logic [FB_LEN_W-1:0] max_len;

    // Word storage, full flag doubles as ingress level
    fifo_0r1w #(.T(fb_word_t), .DEPTH(FB_DEPTH)) u_data_fifo (
        .i_clk, .i_rst_n,
        .i_push(data_push), .i_wdata(data_wdata), .o_full(data_full),
        .i_pop(data_pop), .o_empty(), .o_rdata(data_rdata)
    );

    // Descriptor storage, cannot fill ahead of the data FIFO
    fifo_0r1w #(.T(fb_desc_t), .DEPTH(FB_DEPTH)) u_desc_fifo (
        .i_clk, .i_rst_n,
        .i_push(desc_push), .i_wdata(desc_wdata), .o_full(),
        .i_pop(desc_pop), .o_empty(desc_empty), .o_rdata(desc_rdata)
    );

    frame_writer u_writer (
        .i_clk, .i_rst_n, .i_in_push, .i_in_last, .i_in_data,
        .i_data_full(data_full), .i_max_len(max_len),
        .o_data_push(data_push), .o_data_wdata(data_wdata),
        .o_desc_push(desc_push), .o_desc_wdata(desc_wdata),
        .o_commit(ev_commit), .o_trunc(ev_trunc), .o_drop(ev_drop)
    );

    frame_reader u_reader (
        .i_clk, .i_rst_n,
        .i_desc_empty(desc_empty), .i_desc_rdata(desc_rdata), .i_data_rdata(data_rdata),
        .i_out_pop, .o_out_valid, .o_out_data, .o_out_last, .o_out_trunc,
        .o_data_pop(data_pop), .o_desc_pop(desc_pop)
    );

    fb_csr #(.LEN_W(FB_LEN_W)) u_csr (
        .i_clk, .i_rst_n, .i_csr_we, .i_csr_addr, .i_csr_wdata, .o_csr_rdata,
        .i_commit(ev_commit), .i_trunc(ev_trunc), .i_drop(ev_drop),
        .o_max_len(max_len)
    );

    assign o_in_full = data_full;

endmodule : frame_buffer

`default_nettype wire

//--- testbench/frame_buffer_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIFO protocol checks, bound into every fifo_0r1w instance
// Index width follows the FIFO's own formula for DEPTH
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_checker #(
    parameter int unsigned DEPTH = 16
) (
    input wire logic                                     i_clk,
    input wire logic                                     i_rst_n,
    input wire logic                                     i_push,
    input wire logic                                     i_pop,
    input wire logic                                     i_full,
    input wire logic                                     i_empty,
    input wire logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] i_push_idx,
    input wire logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] i_pop_idx
);

    // Writer must drop words itself, FIFO never sees an overflow
    no_push_when_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push |-> !i_full)
        else $error("push while FIFO full");

    // Reader only pops a stored frame
    no_pop_when_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pop |-> !i_empty)
        else $error("pop while FIFO empty");

    // Wrap by compare keeps both indices inside the array
    idx_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_push_idx < DEPTH) && (i_pop_idx < DEPTH))
        else $error("FIFO index beyond DEPTH");

endmodule : frame_buffer_checker

`default_nettype wire

//--- testbench/frame_buffer_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the frame buffer
// Occupancy model assumes only this bench pops the egress
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_tb import fb_types_pkg::*, fb_csr_pkg::*; ();

    localparam int unsigned SEED     = 32'hb4d5_bf7b;
    localparam int unsigned WAIT_MAX = 20; // Cycles per wait loop

    logic                  i_clk, i_rst_n, i_in_push, i_in_last, i_out_pop, i_csr_we;
    fb_word_t              i_in_data, o_out_data;
    logic                  o_in_full, o_out_valid, o_out_last, o_out_trunc;
    logic [CSR_ADDR_W-1:0] i_csr_addr;
    logic [CSR_DATA_W-1:0] i_csr_wdata, o_csr_rdata;

    fb_word_t    frame_q[$];    // Accepted words of the open frame
    logic        frame_trunc;   // Open frame lost a word
    fb_word_t    exp_data[$];   // One expected egress entry per word
    logic        exp_last[$];
    logic        exp_trunc[$];
    int unsigned occ;           // Words held in the data FIFO
    int unsigned max_len, n_frames, n_trunc, n_drop;

    frame_buffer dut0 (.*);

    bind fifo_0r1w frame_buffer_checker #(.DEPTH(DEPTH)) u_checker (
        .i_clk, .i_rst_n, .i_push, .i_pop, .i_full(o_full), .i_empty(o_empty),
        .i_push_idx(push_idx), .i_pop_idx(pop_idx)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
                                        $time, name, got, exp));
    endtask

    task automatic tick();
        @(posedge i_clk);
        #2;                      // Drive away from the edge
    endtask

    // Model commits or drops the closed frame
    task automatic close_frame();
        int unsigned n;
        n = frame_q.size();
        if (n == 0) begin
            n_drop++;
        end else begin
            n_frames++;
            if (frame_trunc) n_trunc++;
            for (int unsigned i = 0; i < n; i++) begin
                exp_data.push_back(frame_q[i]);
                exp_last.push_back(i == n - 1);
                exp_trunc.push_back(frame_trunc);
            end
        end
        frame_q.delete();
        frame_trunc = 1'b0;
    endtask

    task automatic push_word(input fb_word_t data, input logic last);
        logic kept;
        i_in_push = 1'b1;
        i_in_last = last;
        i_in_data = data;
        check_val("o_in_full", 32'(o_in_full), 32'(occ == FB_DEPTH - 1));
        if ((occ < FB_DEPTH - 1) && (frame_q.size() < max_len)) begin
            frame_q.push_back(data);
            occ++;
        end else begin
            frame_trunc = 1'b1;   // Full or over the limit
        end
        kept = (frame_q.size() != 0);
        if (last) close_frame();
        tick();
        i_in_push = 1'b0;
        i_in_last = 1'b0;
        if (last && kept) check_val("o_out_valid", 32'(o_out_valid), 32'd1); // One cycle later
    endtask

    task automatic send_frame(input int unsigned len);
        for (int unsigned i = 0; i < len; i++) begin
            push_word($urandom(), i == len - 1);
        end
    endtask

    // Pop and compare every expected word at zero latency
    task automatic drain_all();
        int unsigned wait_cnt;
        while (exp_data.size() != 0) begin
            wait_cnt = 0;
            while (!o_out_valid) begin
                if (wait_cnt == WAIT_MAX) stop_with_failure("Timed out waiting for o_out_valid");
                tick();
                wait_cnt++;
            end
            check_val("o_out_data", o_out_data, exp_data.pop_front());
            check_val("o_out_last", 32'(o_out_last), 32'(exp_last.pop_front()));
            check_val("o_out_trunc", 32'(o_out_trunc), 32'(exp_trunc.pop_front()));
            i_out_pop = 1'b1;
            tick();
            i_out_pop = 1'b0;
            occ--;
        end
        check_val("o_out_valid", 32'(o_out_valid), 32'd0); // Dropped frames leave nothing behind
    endtask

    task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input int unsigned data);
        i_csr_we    = 1'b1;
        i_csr_addr  = addr;
        i_csr_wdata = CSR_DATA_W'(data);
        tick();
        i_csr_we = 1'b0;
        if (addr == CSR_MAX_LEN) max_len = (data == 0) ? 1 : data;
    endtask

    // One idle edge first so pending counter pulses land
    task automatic csr_expect(input logic [CSR_ADDR_W-1:0] addr, input int unsigned exp,
                              input string name);
        tick();
        i_csr_addr = addr;
        #1;
        check_val(name, 32'(o_csr_rdata), exp);
    endtask

    initial begin
        void'($urandom(SEED));
        i_rst_n     = 1'b0;
        i_in_push   = 1'b0;
        i_in_last   = 1'b0;
        i_in_data   = '0;
        i_out_pop   = 1'b0;
        i_csr_we    = 1'b0;
        i_csr_addr  = '0;
        i_csr_wdata = '0;
        occ = 0;
        max_len = MAX_LEN_RST;
        n_frames = 0;
        n_trunc = 0;
        n_drop = 0;
        frame_trunc = 1'b0;
        repeat (16) tick();
        i_rst_n = 1'b1;

        check_val("o_out_valid", 32'(o_out_valid), 32'd0);
        check_val("o_in_full", 32'(o_in_full), 32'd0);
        csr_expect(CSR_MAX_LEN, MAX_LEN_RST, "csr max_len");
        csr_expect(CSR_FRAMES, 0, "csr frames");
        csr_expect(CSR_TRUNC, 0, "csr trunc");
        csr_expect(CSR_DROP, 0, "csr drop");

        for (int f = 0; f < 6; f++) begin   // Whole frames of 1 to 8 words
            send_frame(1 + $urandom_range(7, 0));
            drain_all();
        end

        csr_write(CSR_MAX_LEN, 3);          // Six words cut to three
        send_frame(6);
        drain_all();
        csr_expect(CSR_TRUNC, n_trunc, "csr trunc");

        csr_write(CSR_MAX_LEN, 8);          // Third frame meets a full FIFO while egress waits
        repeat (3) send_frame(8);
        check_val("o_in_full", 32'(o_in_full), 32'd1);
        drain_all();
        csr_expect(CSR_DROP, n_drop, "csr drop");
        csr_expect(CSR_TRUNC, n_trunc, "csr trunc");

        csr_expect(CSR_FRAMES, n_frames, "csr frames");
        csr_write(CSR_TRUNC, 0);            // Clear only the truncation counter
        n_trunc = 0;
        csr_expect(CSR_TRUNC, n_trunc, "csr trunc");
        csr_expect(CSR_FRAMES, n_frames, "csr frames");
        csr_expect(CSR_DROP, n_drop, "csr drop");

        $display("TESTS PASSED");
        $finish;
    end

    // Egress must not show a frame before its closing push
    valid_after_close: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_out_valid) |-> $past(i_in_push && i_in_last))
        else stop_with_failure("o_out_valid rose without a closing push one cycle before");

    // Frame leaves egress only when its final word is taken
    valid_falls_on_last_pop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(o_out_valid) |-> $past(i_out_pop && o_out_last))
        else stop_with_failure("o_out_valid fell without a pop of the last word one cycle before");

endmodule : frame_buffer_tb

`default_nettype wire

//--- flist.f
logic/fb_types_pkg.sv
logic/fb_csr_pkg.sv
logic/fifo_0r1w.sv
logic/frame_writer.sv
logic/frame_reader.sv
logic/fb_csr.sv
logic/frame_buffer.sv
testbench/frame_buffer_checker.sv
testbench/frame_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the frame buffer simulation with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module frame_buffer_tb -f flist.f -o frame_buffer_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/frame_buffer_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation ended with an error status"
    exit 1
fi
cat "$LOG"

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass line missing from $LOG"
exit 1
